// ==== all.f ====
rtl/spritePkg.sv
rtl/spriteLaneIf.sv
rtl/spriteSlotScheduler.sv
rtl/spriteRowLookup.sv
rtl/lineCompositor.sv
rtl/spriteLineEngine.sv
test/spriteLineEngineTb.sv

// ==== rtl/lineCompositor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Places each lane's row at its x and merges all lanes into one line
// Output line is active low, registered one cycle after the results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lineCompositor
    import spritePkg::*;
#(
    parameter int numSlots = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             lineTick,   // Request strobe, one cycle after lineStart
    spriteLaneIf.drain       lanes [numSlots],
    output logic             lineValid,
    output logic [lineW-1:0] lineData
);

    logic                           tickD;      // Lines up with the lane results
    logic [numSlots-1:0]            laneValid;
    logic [numSlots-1:0][lineW-1:0] laneLit;    // Lit pixels per lane, active high
    logic [lineW-1:0]               litAny;

    // Shift out of the top drops pixels past the right edge
    for (genvar i = 0; i < numSlots; i++) begin : genLane
        assign laneValid[i] = lanes[i].resValid;
        assign laneLit[i]   = lanes[i].resValid
                            ? ({{(lineW-spriteW){1'b0}}, ~lanes[i].resPixels} << lanes[i].resX)
                            : '0;
    end

    // Any lit lane lights the pixel
    always_comb begin
        litAny = '0;
        for (int i = 0; i < numSlots; i++) begin
            litAny = litAny | laneLit[i];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            tickD     <= 1'b0;
            lineValid <= 1'b0;
        end else begin
            tickD     <= lineTick;
            lineValid <= tickD || (|laneValid);
        end
    end

    always_ff @(posedge clk) begin
        if (tickD) begin
            lineData <= ~litAny;  // Back to active low
        end
    end

endmodule

// ==== rtl/spriteLaneIf.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One sprite lane between scheduler, row lookup and compositor
// Request half from the scheduler, result half from the lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface spriteLaneIf import spritePkg::*; ();

    // Request, valid the cycle after lineStart
    logic               reqValid;
    spriteIdT           reqId;
    orientT             reqOrient;
    rowT                reqRow;     // Row within the sprite
    posT                reqX;

    // Result, one cycle behind the request
    logic               resValid;
    logic [spriteW-1:0] resPixels;  // Bit 0 is the leftmost pixel
    posT                resX;

    modport feeder (
        output reqValid, reqId, reqOrient, reqRow, reqX
    );

    modport lane (
        input  reqValid, reqId, reqOrient, reqRow, reqX,
        output resValid, resPixels, resX
    );

    modport drain (
        input resValid, resPixels, resX
    );

endinterface

// ==== rtl/spriteLineEngine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite line engine top level
// Write slots, strobe lineStart with lineY, and the 64-pixel
// active low line follows on lineValid three cycles later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spriteLineEngine
    import spritePkg::*;
#(
    parameter int numSlots = 4  // 1 to 16
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             slotWrite,
    input  logic [3:0]       slotIndex,
    input  logic             slotEnable,
    input  spriteIdT         slotSpriteId,
    input  orientT           slotOrient,
    input  posT              slotX,
    input  posT              slotY,
    input  logic             lineStart,
    input  posT              lineY,
    output logic             lineValid,
    output logic [lineW-1:0] lineData
);

    logic lineTick;  // Registered lineStart from the scheduler

    spriteLaneIf lanes [numSlots] ();

    spriteSlotScheduler #(
        .numSlots(numSlots)
    ) scheduler (
        .clk          (clk),
        .rstN         (rstN),
        .slotWrite    (slotWrite),
        .slotIndex    (slotIndex),
        .slotEnable   (slotEnable),
        .slotSpriteId (slotSpriteId),
        .slotOrient   (slotOrient),
        .slotX        (slotX),
        .slotY        (slotY),
        .lineStart    (lineStart),
        .lineY        (lineY),
        .lineTick     (lineTick),
        .lanes        (lanes)
    );

    // One lookup per slot
    for (genvar i = 0; i < numSlots; i++) begin : genLookup
        spriteRowLookup rowLookup (
            .clk  (clk),
            .rstN (rstN),
            .lane (lanes[i])
        );
    end

    lineCompositor #(
        .numSlots(numSlots)
    ) compositor (
        .clk       (clk),
        .rstN      (rstN),
        .lineTick  (lineTick),
        .lanes     (lanes),
        .lineValid (lineValid),
        .lineData  (lineData)
    );

endmodule

// ==== rtl/spritePkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the sprite line engine
// Sizes, slot field types, orientation codes and the sprite art table
// Imported by the RTL blocks and the testbench model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package spritePkg;

    localparam int lineW   = 64;  // Pixels per screen line
    localparam int spriteW = 8;   // Sprite edge in pixels

    typedef logic [3:0] spriteIdT;
    typedef logic [1:0] orientT;
    typedef logic [2:0] rowT;
    typedef logic [5:0] posT;     // Screen x or line number

    // Orientation codes
    localparam orientT orientUp    = 2'd0;
    localparam orientT orientRight = 2'd1;  // Quarter turn clockwise
    localparam orientT orientDown  = 2'd2;  // Half turn
    localparam orientT orientLeft  = 2'd3;

    // Active low art, 0 is a lit pixel
    // Bit 7 of each row is the leftmost column of the unrotated sprite
    localparam logic [spriteW-1:0] spriteArt [16][8] = '{
        '{8'b11000111, 8'b10000011, 8'b10000001, 8'b11000000,   // Heart
          8'b11001000, 8'b10010001, 8'b10000011, 8'b11000111},
        '{8'b11101111, 8'b11101111, 8'b11101111, 8'b11101111,   // Sword
          8'b11101111, 8'b11101111, 8'b11000111, 8'b11101111},
        '{8'b11111111, 8'b11000011, 8'b10110000, 8'b00000011,   // Gnome idle 1
          8'b00110001, 8'b00000000, 8'b01000001, 8'b11111111},
        '{8'b11111011, 8'b11100011, 8'b11001000, 8'b11000011,   // Gnome idle 2
          8'b10001001, 8'b10000000, 8'b10010001, 8'b11111111},
        '{8'b11000011, 8'b11100001, 8'b10000011, 8'b10000001,   // Dragon wing up
          8'b00000001, 8'b01000000, 8'b11100001, 8'b11000001},
        '{8'b11000011, 8'b11100001, 8'b11000011, 8'b10000001,   // Dragon wing down
          8'b10000000, 8'b10000000, 8'b10000001, 8'b11000001},
        '{8'b11000111, 8'b11000011, 8'b11000011, 8'b10010001,   // Dragon head
          8'b10110001, 8'b10100001, 8'b01000011, 8'b11000111},
        '{8'b11001111, 8'b10000011, 8'b10011000, 8'b01111011,   // Sheep idle 1
          8'b01111011, 8'b01111000, 8'b10111011, 8'b11000111},
        '{8'b11100111, 8'b11000001, 8'b11001100, 8'b10111101,   // Sheep idle 2
          8'b10111101, 8'b10111100, 8'b11011101, 8'b11100011},
        // Unused ids draw nothing
        '{8{8'hFF}},
        '{8{8'hFF}},
        '{8{8'hFF}},
        '{8{8'hFF}},
        '{8{8'hFF}},
        '{8{8'hFF}},
        '{8{8'hFF}}
    };

endpackage

// ==== rtl/spriteRowLookup.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Oriented sprite row for one lane
// Reads the art table and registers 8 pixels, leftmost in bit 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spriteRowLookup
    import spritePkg::*;
(
    input logic       clk,
    input logic       rstN,
    spriteLaneIf.lane lane
);

    rowT                rowSel;   // Art row for up and down
    logic [spriteW-1:0] artRow;
    logic [spriteW-1:0] artCol;   // Bit r taken from art row r
    logic [spriteW-1:0] pixels;

    // Down reads the rows bottom up
    assign rowSel = (lane.reqOrient == orientDown) ? ~lane.reqRow : lane.reqRow;
    assign artRow = spriteArt[lane.reqId][rowSel];

    // Column for the quarter turns, stored bit k is column 7-k
    always_comb begin
        artCol = '1;
        for (int r = 0; r < spriteW; r++) begin
            artCol[r] = spriteArt[lane.reqId][r][lane.reqRow];
        end
    end

    always_comb begin
        pixels = '1;
        case (lane.reqOrient)
            orientUp: begin
                // Stored bit 7 is the leftmost pixel
                for (int p = 0; p < spriteW; p++) begin
                    pixels[p] = artRow[spriteW-1-p];
                end
            end
            orientDown: begin
                pixels = artRow;  // Reversed rows and columns
            end
            orientRight: begin
                // Bottom art row lands on the left
                for (int p = 0; p < spriteW; p++) begin
                    pixels[p] = artCol[spriteW-1-p];
                end
            end
            default: begin
                pixels = artCol;  // Left, top art row on the left
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lane.resValid <= 1'b0;
        end else begin
            lane.resValid <= lane.reqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (lane.reqValid) begin
            lane.resPixels <= pixels;
            lane.resX      <= lane.reqX;
        end
    end

endmodule

// ==== rtl/spriteSlotScheduler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite slot table and per-line hit test
// Written one slot at a time, issues one registered request per lane
// for every lineStart, plus a tick that follows the request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spriteSlotScheduler
    import spritePkg::*;
#(
    parameter int numSlots = 4
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        slotWrite,
    input  logic [3:0]  slotIndex,
    input  logic        slotEnable,
    input  spriteIdT    slotSpriteId,
    input  orientT      slotOrient,
    input  posT         slotX,
    input  posT         slotY,
    input  logic        lineStart,
    input  posT         lineY,
    output logic        lineTick,
    spriteLaneIf.feeder lanes [numSlots]
);

    // Marks a request cycle, even when no slot hits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lineTick <= 1'b0;
        end else begin
            lineTick <= lineStart;
        end
    end

    for (genvar i = 0; i < numSlots; i++) begin : genSlot
        logic     slotEn;
        spriteIdT slotId;
        orientT   slotOr;
        posT      slotXReg;
        posT      slotYReg;
        logic     writeHit;
        posT      lineOffset;  // Row of the sprite on this line
        logic     lineHit;

        assign writeHit   = slotWrite && (slotIndex == 4'(i));
        assign lineOffset = lineY - slotYReg;
        assign lineHit    = slotEn && (lineY >= slotYReg) && (lineOffset < posT'(spriteW));

        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                slotEn <= 1'b0;  // All slots start disabled
            end else if (writeHit) begin
                slotEn <= slotEnable;
            end
        end

        always_ff @(posedge clk) begin
            if (writeHit) begin
                slotId   <= slotSpriteId;
                slotOr   <= slotOrient;
                slotXReg <= slotX;
                slotYReg <= slotY;
            end
        end

        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                lanes[i].reqValid <= 1'b0;
            end else begin
                lanes[i].reqValid <= lineStart && lineHit;
            end
        end

        // Slot values captured here stay with the line in flight
        always_ff @(posedge clk) begin
            if (lineStart) begin
                lanes[i].reqId     <= slotId;
                lanes[i].reqOrient <= slotOr;
                lanes[i].reqRow    <= lineOffset[2:0];
                lanes[i].reqX      <= slotXReg;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile the sprite line engine testbench with Verilator and run it.
# Exit status is 0 only when the simulation log reports a pass.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module spriteLineEngineTb -f all.f -o simv > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1

grep -q "TEST PASS" sim.log \
    && { echo "Simulation passed, see sim.log"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== test/spriteLineEngineTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the sprite line engine
// Writes slots, requests lines and checks each returned line and its
// latency against a model built on the package art table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spriteLineEngineTb
    import spritePkg::*;
();

    localparam int numSlots    = 4;
    localparam int latency     = 3;
    localparam int resetCycles = 8;

    // Run length, counted per test group
    localparam int numRequests    = 1 + 80 + 32 + 12 + 64 + 3;
    localparam int numWrites      = 10 + 5 + 2 + 4 + 2;
    localparam int drainCycles    = 6 * 10;
    localparam int watchdogCycles = resetCycles + numRequests + numWrites + drainCycles + 100;

    logic             clk;
    logic             rstN;
    logic             slotWrite;
    logic [3:0]       slotIndex;
    logic             slotEnable;
    spriteIdT         slotSpriteId;
    orientT           slotOrient;
    posT              slotX;
    posT              slotY;
    logic             lineStart;
    posT              lineY;
    logic             lineValid;
    logic [lineW-1:0] lineData;

    // Model of the slot table
    int mEn [numSlots];
    int mId [numSlots];
    int mOr [numSlots];
    int mX  [numSlots];
    int mY  [numSlots];

    // Slot write seen by the DUT on the next edge
    bit pendValid;
    int pendIdx, pendEn, pendId, pendOr, pendX, pendY;

    logic [lineW-1:0] expLine [$];
    int               expDue  [$];  // Cycle in which lineValid must be seen

    int          cycle        = 0;
    int          linesChecked = 0;
    int          timingErrors = 0;
    int          dataErrors   = 0;
    logic [31:0] lcgState     = 32'hbbb86354;

    spriteLineEngine #(
        .numSlots(numSlots)
    ) uut (
        .clk          (clk),
        .rstN         (rstN),
        .slotWrite    (slotWrite),
        .slotIndex    (slotIndex),
        .slotEnable   (slotEnable),
        .slotSpriteId (slotSpriteId),
        .slotOrient   (slotOrient),
        .slotX        (slotX),
        .slotY        (slotY),
        .lineStart    (lineStart),
        .lineY        (lineY),
        .lineValid    (lineValid),
        .lineData     (lineData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Upper bits, the low LCG bits repeat quickly
    function automatic int randRange(input int n);
        return int'((nextRand() >> 16) % 32'(n));
    endfunction

    // Expected line from the hit, orientation and composition rules
    function automatic logic [lineW-1:0] expectedLine(input int ly);
        logic [lineW-1:0] line;
        int k, r, c, px;
        line = '1;
        for (int s = 0; s < numSlots; s++) begin
            if (mEn[s] != 0 && ly >= mY[s] && ly - mY[s] < spriteW) begin
                k = ly - mY[s];
                for (int p = 0; p < spriteW; p++) begin
                    case (mOr[s])
                        0: begin
                            r = k;
                            c = p;
                        end
                        1: begin
                            r = 7 - p;
                            c = 7 - k;
                        end
                        2: begin
                            r = 7 - k;
                            c = 7 - p;
                        end
                        default: begin
                            r = p;
                            c = 7 - k;
                        end
                    endcase
                    px = mX[s] + p;
                    if (px < lineW && spriteArt[mId[s]][r][7-c] == 1'b0) begin
                        line[px] = 1'b0;  // Lit, overlaps just AND
                    end
                end
            end
        end
        return line;
    endfunction

    // Next falling edge, strobes cleared
    task automatic nextCycle();
        @(negedge clk);
        if (pendValid) begin
            mEn[pendIdx] = pendEn;
            mId[pendIdx] = pendId;
            mOr[pendIdx] = pendOr;
            mX[pendIdx]  = pendX;
            mY[pendIdx]  = pendY;
            pendValid    = 1'b0;
        end
        slotWrite = 1'b0;
        lineStart = 1'b0;
    endtask

    task automatic setSlot(input int idx, en, id, ori, x, y);
        slotWrite    = 1'b1;
        slotIndex    = 4'(idx);
        slotEnable   = 1'(en);
        slotSpriteId = spriteIdT'(id);
        slotOrient   = orientT'(ori);
        slotX        = posT'(x);
        slotY        = posT'(y);
        pendValid    = 1'b1;  // Model follows after the edge
        pendIdx      = idx;
        pendEn       = en;
        pendId       = id;
        pendOr       = ori;
        pendX        = x;
        pendY        = y;
    endtask

    task automatic setLine(input int ly);
        lineStart = 1'b1;
        lineY     = posT'(ly);
        expLine.push_back(expectedLine(ly));
        expDue.push_back(cycle + latency);
    endtask

    task automatic writeSlot(input int idx, en, id, ori, x, y);
        nextCycle();
        setSlot(idx, en, id, ori, x, y);
    endtask

    task automatic requestLine(input int ly);
        nextCycle();
        setLine(ly);
    endtask

    // Wait for every outstanding line, bounded
    task automatic drainLines();
        nextCycle();
        for (int w = 0; w < 10 && expLine.size() > 0; w++) begin
            @(negedge clk);
        end
    endtask

    // Outputs are stable on the falling edge
    always @(negedge clk) begin : checkOutputs
        logic dueNow;
        if (rstN) begin
            dueNow = (expDue.size() > 0) && (expDue[0] == cycle);
            assert (lineValid == dueNow) else begin
                $display("ERR %0t: lineValid is %0b, expected %0b", $time, lineValid, dueNow);
                timingErrors++;
            end
            if (dueNow) begin
                assert (lineData == expLine[0]) else begin
                    $display("ERR %0t: lineData %h, expected %h", $time, lineData, expLine[0]);
                    dataErrors++;
                end
                linesChecked++;
                void'(expLine.pop_front());
                void'(expDue.pop_front());
            end
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int ids [10] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 12};
        int baseX;
        int baseY;
        rstN         = 1'b0;
        slotWrite    = 1'b0;
        slotIndex    = '0;
        slotEnable   = 1'b0;
        slotSpriteId = '0;
        slotOrient   = orientUp;
        slotX        = '0;
        slotY        = '0;
        lineStart    = 1'b0;
        lineY        = '0;
        pendValid    = 1'b0;
        for (int s = 0; s < numSlots; s++) begin
            mEn[s] = 0;
            mId[s] = 0;
            mOr[s] = 0;
            mX[s]  = 0;
            mY[s]  = 0;
        end
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        // Reset state and an empty line
        @(negedge clk);
        assert (lineValid == 1'b0) else begin
            $display("ERR %0t: lineValid high after reset", $time);
            timingErrors++;
        end
        requestLine(10);
        drainLines();

        // Every art entry upright at x 0
        foreach (ids[i]) begin
            writeSlot(0, 1, ids[i], orientUp, 0, 0);
            for (int ly = 0; ly < spriteW; ly++) requestLine(ly);
        end
        drainLines();

        // Dragon head in all four orientations
        writeSlot(0, 0, 0, orientUp, 0, 0);
        for (int o = 0; o < 4; o++) begin
            writeSlot(1, 1, 6, o, 20, 30);
            for (int ly = 30; ly < 38; ly++) requestLine(ly);
        end
        drainLines();

        // Lines just outside the slot, right edge clip, no vertical wrap
        requestLine(29);
        requestLine(38);
        writeSlot(2, 1, 0, orientUp, 60, 40);
        writeSlot(3, 1, 1, orientLeft, 30, 60);
        for (int ly = 40; ly < 48; ly++) requestLine(ly);
        requestLine(63);
        requestLine(2);
        drainLines();

        // Random slots, 0 and 1 overlap, one line every cycle
        baseX = randRange(lineW - spriteW);
        baseY = randRange(48);
        writeSlot(0, 1, randRange(9), randRange(4), baseX, baseY);
        writeSlot(1, 1, randRange(9), randRange(4), baseX + 3, baseY + 2);
        writeSlot(2, 1, randRange(9), randRange(4), randRange(lineW), randRange(57));
        writeSlot(3, 1, randRange(9), randRange(4), randRange(lineW), randRange(57));
        for (int ly = 0; ly < lineW; ly++) requestLine(ly);
        drainLines();

        // Rewrite in the same cycle as a request, the next one sees it
        writeSlot(3, 1, 1, orientUp, 10, 50);
        requestLine(52);
        nextCycle();
        setSlot(3, 1, 7, orientRight, 12, 50);
        setLine(52);
        requestLine(52);
        drainLines();

        $display("Lines checked: %0d, timing errors: %0d, data errors: %0d",
                 linesChecked, timingErrors, dataErrors);
        if (timingErrors == 0 && dataErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
